// ==== Makefile ====
# Verilator build and run of the I2C port expander testbench
TOP := tb_i2c_io_expander

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -Mdir obj_dir -o sim_$(TOP)

# the run fails unless the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// ==== common/i2c_bus_pkg.sv ====
// bus-side definitions for the I2C port expander, imported by the sampler, the engine and the checker
package i2c_bus_pkg;

    // 7-bit device address, matched against the first byte of every transfer
    localparam logic [6:0] slave_address = 7'h27;

    // one set of bus observations per SCL cycle, all taken from synchronized lines
    typedef struct packed {
        logic scl_rise;  // one-cycle strobe when bus_scl goes high
        logic scl_fall;  // one-cycle strobe when bus_scl goes low
        logic start;     // sda fell while scl was high, repeated starts included
        logic stop;      // sda rose while scl was high
        logic sda;       // synchronized data level, the wired-AND of all drivers
    } bus_event_t;

    // first byte of a transfer carries the address in the upper seven bits
    typedef struct packed {
        logic [6:0] addr;  // target device address, sent msb first
        logic       rw;    // high selects a read transfer
    } addr_byte_t;

    // the same eight bits are read either as an address byte or as plain data
    typedef union packed {
        addr_byte_t addr_byte;  // decoded only for the first byte after a start
        logic [7:0] data_byte;  // every later byte, written to or read from the port
    } i2c_byte_t;

endpackage

// ==== common/io_port_pkg.sv ====
// port-side definitions shared by the byte engine, the port register and the top level
package io_port_pkg;

    // number of output pins, one I2C data byte wide
    localparam int port_width = 8;

    // write request from the protocol engine to the port register
    typedef struct packed {
        logic                  strobe;  // high for the one cycle that loads the port
        logic [port_width-1:0] value;   // byte received from the master
    } port_write_t;

endpackage

// ==== filelist.f ====
+incdir+verification
common/i2c_bus_pkg.sv
common/io_port_pkg.sv
verilog/bus_sampler.sv
i2c_slave/i2c_byte_engine.sv
verilog/io_port_regs.sv
verilog/i2c_io_expander.sv
verification/i2c_io_expander_chk.sv
verification/tb_i2c_io_expander.sv

// ==== i2c_slave/i2c_byte_engine.sv ====
// I2C slave protocol engine: counts bits, matches the address, acks, and moves port bytes
module i2c_byte_engine
    import i2c_bus_pkg::*;
    import io_port_pkg::*;
(
    input  logic                  SCL,
    input  logic                  reset,
    input  bus_event_t            events,        // strobes and sda level from the sampler
    input  logic [port_width-1:0] port_value,    // current port state, shifted out on reads
    output port_write_t           port_write,    // load request for the port register
    output logic                  sda_pull_low   // high pulls the open-drain sda line low
);

    logic       in_transfer;  // between a start and the following stop
    logic [3:0] bit_cnt;      // 7 down to 0 for data bits, 15 is the ack slot, 8 waits after start
    logic       data_phase;   // low while the address byte is on the bus
    logic       addr_match;   // the address byte named this device
    logic       op_read;      // rw bit of the address byte
    logic       got_ack;      // master acked the last byte, our own address ack counts too
    i2c_byte_t  shift_reg;    // received byte, or the byte being sent on a read
    logic       drive_q;      // drive level held between fall strobes
    logic       drive_d;      // drive level for the coming bit period
    logic       ack_slot;
    logic       addr_hit;
    logic       read_active;
    logic       read_data;

    assign ack_slot    = (bit_cnt == 4'hf);
    assign addr_hit    = (shift_reg.addr_byte.addr == slave_address);
    assign read_active = addr_match & op_read & got_ack;  // master still wants bytes
    assign read_data   = data_phase & read_active;

    // the drive for the next bit is worked out here so that sda moves in the very cycle
    // the fall strobe arrives, which leaves the master the whole low half for setup
    always_comb
    begin
        drive_d = drive_q;
        if (events.start | events.stop)
            drive_d = 1'b0;  // a bus condition always releases the line
        else if (events.scl_fall & in_transfer)
        begin
            if (bit_cnt == 4'h0)
            begin
                // entering the ack slot: ack our address, and every byte of a matched write
                if (data_phase)
                    drive_d = addr_match & ~op_read;
                else
                    drive_d = addr_hit;
            end
            else if (ack_slot)
                drive_d = read_active & ~port_value[port_width-1];  // msb of a fresh read byte
            else
                drive_d = read_data & ~shift_reg.data_byte[6];  // next bit once this one shifts
        end
    end

    assign sda_pull_low = drive_d;

    // the write leaves on the fall that ends the eighth data bit, the port loads one cycle later
    always_comb
    begin
        port_write.strobe = events.scl_fall & in_transfer & ~events.start & ~events.stop
                          & data_phase & addr_match & ~op_read & (bit_cnt == 4'h0);
        port_write.value  = shift_reg.data_byte;
    end

    // protocol control state
    always_ff @(posedge SCL)
    begin
        if (reset)
        begin
            in_transfer <= 1'b0;
            bit_cnt     <= 4'h8;
            data_phase  <= 1'b0;
            addr_match  <= 1'b0;
            op_read     <= 1'b0;
            got_ack     <= 1'b0;
            drive_q     <= 1'b0;
        end
        else
        begin
            drive_q <= drive_d;
            if (events.start)
            begin
                // any start, repeated or not, goes back to the address byte
                in_transfer <= 1'b1;
                bit_cnt     <= 4'h8;  // the fall that closes the start brings bit 7
                data_phase  <= 1'b0;
                addr_match  <= 1'b0;
                op_read     <= 1'b0;
                got_ack     <= 1'b0;
            end
            else if (events.stop)
                in_transfer <= 1'b0;
            else if (in_transfer)
            begin
                // a nack on a read sticks until the next start
                if (events.scl_rise & ack_slot)
                    got_ack <= ~events.sda & (got_ack | ~data_phase);
                if (events.scl_fall)
                begin
                    if (ack_slot)
                    begin
                        bit_cnt    <= 4'h7;
                        data_phase <= 1'b1;
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt - 4'h1;  // 0 wraps to 15, the ack slot
                        if ((bit_cnt == 4'h0) & ~data_phase)
                        begin
                            addr_match <= addr_hit;
                            op_read    <= shift_reg.addr_byte.rw;
                        end
                    end
                end
            end
        end
    end

    // shift register, filled from sda on writes and emptied msb first on reads
    always_ff @(posedge SCL)
    begin
        if (in_transfer & ~events.start & ~events.stop)
        begin
            if (events.scl_rise & ~ack_slot & ~read_data)
                shift_reg.data_byte <= {shift_reg.data_byte[6:0], events.sda};
            else if (events.scl_fall & ack_slot & read_active)
                shift_reg.data_byte <= port_value;  // reload for every acked read byte
            else if (events.scl_fall & ~ack_slot & read_data)
                shift_reg.data_byte <= {shift_reg.data_byte[6:0], 1'b0};
        end
    end

endmodule

// ==== verification/i2c_io_expander_chk.sv ====
// protocol assertions on the byte engine's sda drive and port writes, bound into the engine
module i2c_io_expander_chk
    import i2c_bus_pkg::*;
    import io_port_pkg::*;
(
    input logic        SCL,
    input logic        reset,
    input bus_event_t  events,
    input logic        in_transfer,
    input logic        data_phase,
    input logic        addr_match,
    input logic        op_read,
    input port_write_t port_write,
    input logic        sda_pull_low
);

    // outside a transfer the line belongs to the master alone
    drive_only_in_transfer: assert property (@(posedge SCL) disable iff (reset)
        !in_transfer |-> !sda_pull_low)
        else $error("sda_pull_low is high outside a transfer");

    // the port only loads from a data byte written to our own address,
    // and the engine acks that very byte in the same cycle
    write_only_when_matched: assert property (@(posedge SCL) disable iff (reset)
        port_write.strobe |-> (data_phase && addr_match && !op_read && sda_pull_low))
        else $error("port write strobe outside the acked data phase of a matched write");

    // sda may only move on a bus_scl fall or at a bus condition
    drive_moves_on_fall: assert property (@(posedge SCL) disable iff (reset)
        (sda_pull_low != $past(sda_pull_low)) |-> (events.scl_fall || events.start || events.stop))
        else $error("sda_pull_low changed without a scl fall, start or stop");

endmodule

bind i2c_byte_engine i2c_io_expander_chk chk0 (
    .SCL          (SCL),
    .reset        (reset),
    .events       (events),
    .in_transfer  (in_transfer),
    .data_phase   (data_phase),
    .addr_match   (addr_match),
    .op_read      (op_read),
    .port_write   (port_write),
    .sda_pull_low (sda_pull_low)
);

// ==== verification/i2c_master_bfm.svh ====
// I2C bus master tasks, included into the testbench module to drive master_scl and master_sda
`ifndef I2C_MASTER_BFM_SVH
`define I2C_MASTER_BFM_SVH

// waits n clock cycles and ends just after a rising edge, where the testbench moves its inputs
task automatic wait_cycles(input int n);
    repeat (n) @(posedge SCL);
    #2;
endtask

// one bit period that begins at a bus_scl fall and ends at the next fall
task automatic clock_bit(input logic sda_out, output logic sda_in);
    wait_cycles(setup_cycles);  // the device moves its drive three cycles after the fall
    master_sda = sda_out;
    wait_cycles(half_cycles - setup_cycles);
    master_scl = 1'b1;
    wait_cycles(half_cycles);
    sda_in     = bus_sda;  // wired-AND level at the very end of the high half
    master_scl = 1'b0;
endtask

// start from an idle bus, or a repeated start from the low half after a byte
task automatic send_start();
    if (master_scl == 1'b0)
    begin
        // sda has to go high while scl is still low, otherwise this would look like a stop
        wait_cycles(setup_cycles);
        master_sda = 1'b1;
        wait_cycles(half_cycles - setup_cycles);
        master_scl = 1'b1;
        wait_cycles(half_cycles);
    end
    master_sda = 1'b0;  // sda falls with scl high
    wait_cycles(half_cycles);
    master_scl = 1'b0;
endtask

// stop from the low half after a byte, leaves the bus idle with both lines high
task automatic send_stop();
    wait_cycles(setup_cycles);
    master_sda = 1'b0;
    wait_cycles(half_cycles - setup_cycles);
    master_scl = 1'b1;
    wait_cycles(half_cycles);
    master_sda = 1'b1;  // sda rises with scl high
    wait_cycles(half_cycles);
endtask

// sends eight bits msb first, then releases sda and returns the acknowledge level it saw
task automatic send_byte(input i2c_byte_t value, output logic ack);
    logic echo;  // our own bit coming back, of no interest here
    for (int i = 7; i >= 0; i--)
        clock_bit(value.data_byte[i], echo);
    clock_bit(1'b1, ack);  // low means the device acknowledged
endtask

// reads eight bits msb first with sda released, then acknowledges or refuses the byte
task automatic read_byte(input logic give_ack, output i2c_byte_t value);
    logic level;
    logic echo;
    for (int i = 7; i >= 0; i--)
    begin
        clock_bit(1'b1, level);
        value.data_byte[i] = level;
    end
    clock_bit(~give_ack, echo);  // a high level here ends the read for the device
endtask

`endif

// ==== verification/tb_i2c_io_expander.sv ====
// testbench for the I2C port expander, random bus transfers checked against a port model
module tb_i2c_io_expander
    import i2c_bus_pkg::*;
    import io_port_pkg::*;
();

    localparam int clk_period   = 40;
    localparam int reset_cycles = 8;
    localparam int half_cycles  = 12;  // bus half-period in SCL cycles
    localparam int setup_cycles = 4;   // wait after a bus_scl fall before the master moves sda
    localparam int n_trans      = 40;
    localparam int max_bytes    = 4;
    // eight bits and the acknowledge, each a low and a high half
    localparam int byte_cycles  = 9 * 2 * half_cycles;
    // two transfers of address plus max_bytes, and start, repeated start, stop and gap on top
    localparam int trans_cycles   = 2 * (max_bytes + 1) * byte_cycles + 12 * half_cycles;
    localparam int timeout_cycles = reset_cycles + 100 + n_trans * trans_cycles;

    logic                  SCL;
    logic                  reset;
    logic                  master_scl;
    logic                  master_sda;    // level the master puts on sda, high means released
    logic                  bus_sda;       // the wired-AND line as every device sees it
    logic                  sda_pull_low;
    logic [port_width-1:0] io_out;

    logic [port_width-1:0] model_port;    // expected pin state
    logic                  quiet_bus;     // high while the device must not pull sda low
    int                    quiet_hits = 0;
    int                    checks = 0;
    int                    port_errors = 0;
    int                    ack_errors = 0;
    int                    read_errors = 0;
    int                    bus_errors = 0;

    assign bus_sda = master_sda & ~sda_pull_low;  // open drain, either side can pull low

    i2c_io_expander dut0 (
        .SCL          (SCL),
        .reset        (reset),
        .bus_scl      (master_scl),
        .bus_sda      (bus_sda),
        .sda_pull_low (sda_pull_low),
        .io_out       (io_out)
    );

    `include "i2c_master_bfm.svh"

    initial
    begin
        SCL = 1'b0;
        forever #(clk_period / 2) SCL = ~SCL;
    end

    // the run cannot take longer than every transaction at its worst plus some slack
    initial
    begin
        #(timeout_cycles * clk_period);
        $display("timeout after %0d clock cycles, the bus master never got done", timeout_cycles);
        $display("tests failed");
        $finish;
    end

    // counts cycles in which the device pulls sda while it should keep off the bus
    always @(posedge SCL)
    begin
        if (!reset && quiet_bus && sda_pull_low !== 1'b0)
            quiet_hits <= quiet_hits + 1;
    end

    task automatic check_port(input logic [port_width-1:0] expected,
                              input logic [port_width-1:0] actual);
        checks++;
        if (actual !== expected)
        begin
            port_errors++;
            $display("FAIL io_out expected 0x%h got 0x%h at %0t", expected, actual, $time);
        end
    endtask

    task automatic check_ack(input logic expected, input logic actual);
        checks++;
        if (actual !== expected)
        begin
            ack_errors++;
            $display("FAIL sda_ack expected 0x%h got 0x%h at %0t", expected, actual, $time);
        end
    endtask

    task automatic check_read(input i2c_byte_t expected, input i2c_byte_t actual);
        checks++;
        if (actual !== expected)
        begin
            read_errors++;
            $display("FAIL read_byte expected 0x%h got 0x%h at %0t",
                     expected.data_byte, actual.data_byte, $time);
        end
    endtask

    // address byte and count bytes after a start, without the closing stop
    task automatic run_transfer(input logic [6:0] addr, input logic rw, input int count);
        i2c_byte_t head;
        i2c_byte_t data;
        i2c_byte_t expected;
        logic      own;
        logic      ack;
        logic      give_ack;
        logic      released;  // device is done with this transfer and keeps sda high
        own       = (addr == slave_address);
        released  = ~own;
        quiet_bus = ~own;  // a foreign transfer must see no drive from the first bit on
        head.addr_byte.addr = addr;
        head.addr_byte.rw   = rw;
        send_byte(head, ack);
        check_ack(~own, ack);
        for (int k = 0; k < count; k++)
        begin
            if (rw == 1'b0)
            begin
                data.data_byte = 8'($urandom);
                send_byte(data, ack);
                check_ack(~own, ack);  // only our own address acks its data
                if (own)
                    model_port = data.data_byte;
            end
            else
            begin
                // the last byte is always refused so that the stop finds sda free
                give_ack = (k < count - 1) ? 1'($urandom) : 1'b0;
                expected.data_byte = released ? 8'hff : model_port;
                read_byte(give_ack, data);
                check_read(expected, data);
                if (!give_ack)
                begin
                    released  = 1'b1;
                    quiet_bus = 1'b1;
                end
            end
        end
    endtask

    initial
    begin
        int unsigned seed_ret;
        logic [6:0]  addr;
        logic        rw;
        logic        chain;
        int          count;
        int          count2;
        int          hits_before;
        int          total;
        reset      = 1'b1;
        master_scl = 1'b1;
        master_sda = 1'b1;
        quiet_bus  = 1'b1;  // nothing may pull the bus before the first transfer
        model_port = '0;
        seed_ret   = $urandom(32'hb0bd);
        repeat (reset_cycles) @(posedge SCL);
        #2;
        reset = 1'b0;
        wait_cycles(2 * half_cycles);
        check_port(model_port, io_out);  // pins come out of reset low
        if (quiet_hits != 0)
        begin
            bus_errors++;
            $display("the device pulled SDA low on the idle bus right after reset");
        end
        for (int t = 0; t < n_trans; t++)
        begin
            // own address about half the time, else anything but it
            if (1'($urandom))
                addr = slave_address;
            else
            begin
                addr = 7'($urandom);
                if (addr == slave_address)
                    addr = addr ^ 7'h01;
            end
            rw     = 1'($urandom);
            count  = $urandom_range(max_bytes, 1);
            count2 = $urandom_range(max_bytes, 1);
            chain  = ($urandom_range(3, 0) == 0);  // a repeated start into a write now and then
            hits_before = quiet_hits;
            send_start();
            run_transfer(addr, rw, count);
            if (chain)
            begin
                send_start();
                run_transfer(slave_address, 1'b0, count2);
            end
            send_stop();
            quiet_bus = 1'b1;
            wait_cycles(2 * half_cycles);
            check_port(model_port, io_out);  // the last byte written stays on the pins
            if (quiet_hits != hits_before)
            begin
                bus_errors++;
                $display("the device pulled SDA low while it had to leave the bus, transaction %0d",
                         t);
            end
        end
        total = port_errors + ack_errors + read_errors + bus_errors;
        $display("%0d checks, %0d errors (port %0d, ack %0d, read %0d, bus %0d)",
                 checks, total, port_errors, ack_errors, read_errors, bus_errors);
        if (total == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== verilog/bus_sampler.sv ====
// samples the raw bus lines on SCL and reports edges, start and stop to the byte engine
module bus_sampler
    import i2c_bus_pkg::*;
(
    input  logic       SCL,
    input  logic       reset,
    input  logic       bus_scl,   // bus clock line, asynchronous to SCL
    input  logic       bus_sda,   // bus data line, asynchronous to SCL
    output bus_event_t events
);

    logic scl_meta;  // first synchronizer stage, may go metastable
    logic scl_sync;  // second stage, safe to use
    logic scl_prev;  // previous synchronized value for edge detection
    logic sda_meta;
    logic sda_sync;
    logic sda_prev;

    // two-flop synchronizers, reset to the idle bus level so no edge is seen at startup
    always_ff @(posedge SCL)
    begin
        if (reset)
        begin
            scl_meta <= 1'b1;
            scl_sync <= 1'b1;
            sda_meta <= 1'b1;
            sda_sync <= 1'b1;
        end
        else
        begin
            scl_meta <= bus_scl;
            scl_sync <= scl_meta;
            sda_meta <= bus_sda;
            sda_sync <= sda_meta;
        end
    end

    // the third flop holds last cycle's lines and registers the events together,
    // so a pin change shows up here exactly three cycles later
    always_ff @(posedge SCL)
    begin
        if (reset)
        begin
            scl_prev <= 1'b1;
            sda_prev <= 1'b1;
            events   <= '{scl_rise: 1'b0, scl_fall: 1'b0, start: 1'b0, stop: 1'b0, sda: 1'b1};
        end
        else
        begin
            scl_prev        <= scl_sync;
            sda_prev        <= sda_sync;
            events.scl_rise <= scl_sync & ~scl_prev;
            events.scl_fall <= ~scl_sync & scl_prev;
            // data may only move while scl is low, so an sda edge with scl high both before
            // and after is a start or a stop
            events.start    <= scl_sync & scl_prev & sda_prev & ~sda_sync;
            events.stop     <= scl_sync & scl_prev & ~sda_prev & sda_sync;
            events.sda      <= sda_sync;  // level handed on with the same latency as the strobes
        end
    end

endmodule

// ==== verilog/i2c_io_expander.sv ====
// top level of the I2C output port expander, wiring sampler, byte engine and port register
module i2c_io_expander
    import i2c_bus_pkg::*;
    import io_port_pkg::*;
(
    input  logic                  SCL,
    input  logic                  reset,
    input  logic                  bus_scl,       // bus clock from the master
    input  logic                  bus_sda,       // wired-AND data line as seen at the pin
    output logic                  sda_pull_low,  // open-drain enable, high means pull low
    output logic [port_width-1:0] io_out         // output pins
);

    bus_event_t  bus_events;   // sampler to engine
    port_write_t eng_write;    // engine to port register

    bus_sampler sampler0 (
        .SCL     (SCL),
        .reset   (reset),
        .bus_scl (bus_scl),
        .bus_sda (bus_sda),
        .events  (bus_events)
    );

    // the engine reads the pins back directly for read transfers
    i2c_byte_engine engine0 (
        .SCL          (SCL),
        .reset        (reset),
        .events       (bus_events),
        .port_value   (io_out),
        .port_write   (eng_write),
        .sda_pull_low (sda_pull_low)
    );

    io_port_regs port0 (
        .SCL        (SCL),
        .reset      (reset),
        .port_write (eng_write),
        .port_value (io_out)
    );

endmodule

// ==== verilog/io_port_regs.sv ====
// output port register of the expander, loaded by the byte engine and read back on I2C reads
module io_port_regs
    import io_port_pkg::*;
(
    input  logic                  SCL,
    input  logic                  reset,
    input  port_write_t           port_write,  // one-cycle load request from the engine
    output logic [port_width-1:0] port_value   // drives the pins and feeds reads
);

    logic [port_width-1:0] port_q;  // pin state, untouched by restarts and bus errors

    // only a completed write byte moves the pins, so an aborted transfer leaves them alone
    always_ff @(posedge SCL)
    begin
        if (reset)
            port_q <= '0;  // pins come up low
        else if (port_write.strobe)
            port_q <= port_write.value;
    end

    assign port_value = port_q;

endmodule
